// File: Makefile
TOP = tb_top
LOG = sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f sources.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f sources.f --top-module $(TOP) -Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	grep -q "All tests passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: hdl/io_access_splitter.sv
/* I/O request capture and split */

`timescale 1ns/1ns

module io_access_splitter (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 io_read_do,
    input  logic                                 io_write_do,
    input  logic [io_bus_pkg::IO_ADDR_W-1:0]     io_address,
    input  io_ctrl_pkg::io_len_t                 io_length,
    input  logic [io_bus_pkg::IO_DATA_W-1:0]     io_write_data,
    output logic                                 req_start,
    output logic                                 req_write,
    output logic                                 req_split,
    output logic [io_bus_pkg::IO_ADDR_W-1:0]     dword_addr,
    output logic [io_bus_pkg::IO_BE_W-1:0]       be_first,
    output logic [io_bus_pkg::IO_BE_W-1:0]       be_second,
    output logic [1:0]                           req_offset,
    output io_ctrl_pkg::io_len_t                 req_length,
    output logic [io_bus_pkg::IO_DATA_W-1:0]     req_data
);

    import io_bus_pkg::*;
    import io_ctrl_pkg::*;

    logic                   req_do;
    logic [IO_BE_W-1:0]     len_mask;     // one bit per requested byte
    logic [2*IO_BE_W-1:0]   lane_span;    // lanes over two dwords

    assign req_do = io_read_do | io_write_do;

    always_comb begin
        case (io_length)
            3'd1:    len_mask = 4'b0001;
            3'd2:    len_mask = 4'b0011;
            3'd3:    len_mask = 4'b0111;
            default: len_mask = 4'b1111;
        endcase
    end

    // upper half set only when offset plus length runs past lane 3
    assign lane_span = {{IO_BE_W{1'b0}}, len_mask} << io_address[1:0];

    // ----------------------------------------
    // request registers
    // ----------------------------------------

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            req_start <= 1'b0;
        end else begin
            req_start <= req_do;   // master sees the request a cycle later
        end
    end

    always_ff @(posedge clk) begin
        if (req_do) begin
            req_write  <= io_write_do;
            req_split  <= |lane_span[2*IO_BE_W-1:IO_BE_W];
            dword_addr <= {io_address[IO_ADDR_W-1:2], 2'b00};
            be_first   <= lane_span[IO_BE_W-1:0];
            be_second  <= lane_span[2*IO_BE_W-1:IO_BE_W];
            req_offset <= io_address[1:0];
            req_length <= io_length;
            req_data   <= io_write_data;
        end
    end

    // ----------------------------------------
    // core side protocol
    // ----------------------------------------

    a_length_legal: assert property (@(posedge clk) disable iff (!rst_n)
        req_do |-> (io_length >= 3'd1 && io_length <= IO_MAX_LEN));

    a_one_strobe: assert property (@(posedge clk) disable iff (!rst_n)
        !(io_read_do && io_write_do));

endmodule

// File: hdl/io_avalon_master.sv
/* Avalon I/O bus master */

`timescale 1ns/1ns

module io_avalon_master (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 req_start,
    input  logic                                 req_write,
    input  logic                                 req_split,
    input  logic [io_bus_pkg::IO_ADDR_W-1:0]     dword_addr,
    input  logic [io_bus_pkg::IO_BE_W-1:0]       be_first,
    input  logic [io_bus_pkg::IO_BE_W-1:0]       be_second,
    input  logic                                 avalon_io_waitrequest,
    input  logic                                 avalon_io_readdatavalid,
    output logic [io_bus_pkg::IO_ADDR_W-1:0]     avalon_io_address,
    output logic [io_bus_pkg::IO_BE_W-1:0]       avalon_io_byteenable,
    output logic                                 avalon_io_read,
    output logic                                 avalon_io_write,
    output io_ctrl_pkg::io_phase_e               phase,
    output logic                                 rd_capture,
    output logic                                 last_capture,
    output logic                                 io_read_done,
    output logic                                 io_write_done
);

    import io_bus_pkg::*;
    import io_ctrl_pkg::*;

    localparam logic [1:0] ST_IDLE  = 2'd0;
    localparam logic [1:0] ST_ISSUE = 2'd1;   // read or write on the bus
    localparam logic [1:0] ST_WAIT  = 2'd2;   // read accepted, data pending
    localparam logic [1:0] ST_DONE  = 2'd3;

    localparam logic [IO_ADDR_W-1:0] DWORD_STEP = 4;

    logic [1:0] state;
    logic       bus_accept;
    logic       last_phase;

    assign bus_accept = (avalon_io_read | avalon_io_write) & ~avalon_io_waitrequest;
    assign last_phase = ~req_split | (phase == phase_second);

    // ----------------------------------------
    // transaction sequencer
    // ----------------------------------------

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state           <= ST_IDLE;
            phase           <= phase_first;
            avalon_io_read  <= 1'b0;
            avalon_io_write <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (req_start) begin
                        state           <= ST_ISSUE;
                        phase           <= phase_first;
                        avalon_io_read  <= ~req_write;
                        avalon_io_write <= req_write;
                    end
                end
                ST_ISSUE: begin
                    if (bus_accept) begin
                        if (avalon_io_read) begin
                            avalon_io_read <= 1'b0;
                            state          <= ST_WAIT;
                        end else if (last_phase) begin
                            avalon_io_write <= 1'b0;
                            state           <= ST_DONE;
                        end else begin
                            phase <= phase_second;   // write stays up for next dword
                        end
                    end
                end
                ST_WAIT: begin
                    if (avalon_io_readdatavalid) begin
                        if (last_phase) begin
                            state <= ST_DONE;
                        end else begin
                            phase          <= phase_second;
                            avalon_io_read <= 1'b1;
                            state          <= ST_ISSUE;
                        end
                    end
                end
                default: begin
                    state <= ST_IDLE;   // done lasts one cycle
                end
            endcase
        end
    end

    // ----------------------------------------
    // bus address and strobes
    // ----------------------------------------

    assign avalon_io_address    = (phase == phase_second) ? dword_addr + DWORD_STEP : dword_addr;
    assign avalon_io_byteenable = (phase == phase_second) ? be_second : be_first;

    assign rd_capture   = avalon_io_readdatavalid & (state == ST_WAIT);
    assign last_capture = rd_capture & last_phase;

    assign io_read_done  = (state == ST_DONE) & ~req_write;
    assign io_write_done = (state == ST_DONE) & req_write;

    // ----------------------------------------
    // bus protocol
    // ----------------------------------------

    a_rd_wr_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(avalon_io_read && avalon_io_write));

    // slave must not return data that was never asked for
    a_rdv_outstanding: assert property (@(posedge clk) disable iff (!rst_n)
        avalon_io_readdatavalid |-> (state == ST_WAIT));

    a_hold_on_wait: assert property (@(posedge clk) disable iff (!rst_n)
        (avalon_io_read || avalon_io_write) && avalon_io_waitrequest
        |=> (avalon_io_read || avalon_io_write) && $stable(avalon_io_address)
            && $stable(avalon_io_byteenable));

endmodule

// File: hdl/io_bridge_top.sv
/* I/O port bridge top */

`timescale 1ns/1ns

module io_bridge_top (
    input  logic                                 clk,
    input  logic                                 rst_n,

    // core side
    input  logic                                 io_read_do,
    input  logic                                 io_write_do,
    input  logic [io_bus_pkg::IO_ADDR_W-1:0]     io_address,
    input  io_ctrl_pkg::io_len_t                 io_length,
    input  logic [io_bus_pkg::IO_DATA_W-1:0]     io_write_data,
    output logic [io_bus_pkg::IO_DATA_W-1:0]     io_read_data,
    output logic                                 io_read_done,
    output logic                                 io_write_done,

    // avalon io bus
    output logic [io_bus_pkg::IO_ADDR_W-1:0]     avalon_io_address,
    output logic [io_bus_pkg::IO_BE_W-1:0]       avalon_io_byteenable,
    output logic                                 avalon_io_read,
    input  logic                                 avalon_io_readdatavalid,
    input  logic [io_bus_pkg::IO_DATA_W-1:0]     avalon_io_readdata,
    output logic                                 avalon_io_write,
    output logic [io_bus_pkg::IO_DATA_W-1:0]     avalon_io_writedata,
    input  logic                                 avalon_io_waitrequest
);

    import io_bus_pkg::*;
    import io_ctrl_pkg::*;

    // ----------------------------------------
    // splitter outputs
    // ----------------------------------------

    logic                   req_start;
    logic                   req_write;
    logic                   req_split;
    logic [IO_ADDR_W-1:0]   dword_addr;
    logic [IO_BE_W-1:0]     be_first;
    logic [IO_BE_W-1:0]     be_second;
    logic [1:0]             req_offset;
    io_len_t                req_length;
    logic [IO_DATA_W-1:0]   req_data;

    // master to aligner
    io_phase_e              phase;
    logic                   rd_capture;
    logic                   last_capture;

    io_access_splitter splitter_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .io_read_do     (io_read_do),       //input
        .io_write_do    (io_write_do),      //input
        .io_address     (io_address),       //input [15:0]
        .io_length      (io_length),        //input [2:0]
        .io_write_data  (io_write_data),    //input [31:0]
        .req_start      (req_start),        //output
        .req_write      (req_write),        //output
        .req_split      (req_split),        //output
        .dword_addr     (dword_addr),       //output [15:0]
        .be_first       (be_first),         //output [3:0]
        .be_second      (be_second),        //output [3:0]
        .req_offset     (req_offset),       //output [1:0]
        .req_length     (req_length),       //output [2:0]
        .req_data       (req_data)          //output [31:0]
    );

    io_avalon_master master_inst (
        .clk                        (clk),
        .rst_n                      (rst_n),
        .req_start                  (req_start),                //input
        .req_write                  (req_write),                //input
        .req_split                  (req_split),                //input
        .dword_addr                 (dword_addr),               //input [15:0]
        .be_first                   (be_first),                 //input [3:0]
        .be_second                  (be_second),                //input [3:0]
        .avalon_io_waitrequest      (avalon_io_waitrequest),    //input
        .avalon_io_readdatavalid    (avalon_io_readdatavalid),  //input
        .avalon_io_address          (avalon_io_address),        //output [15:0]
        .avalon_io_byteenable       (avalon_io_byteenable),     //output [3:0]
        .avalon_io_read             (avalon_io_read),           //output
        .avalon_io_write            (avalon_io_write),          //output
        .phase                      (phase),                    //output
        .rd_capture                 (rd_capture),               //output
        .last_capture               (last_capture),             //output
        .io_read_done               (io_read_done),             //output
        .io_write_done              (io_write_done)             //output
    );

    io_data_aligner aligner_inst (
        .clk                    (clk),
        .rst_n                  (rst_n),
        .phase                  (phase),                //input
        .rd_capture             (rd_capture),           //input
        .last_capture           (last_capture),         //input
        .req_offset             (req_offset),           //input [1:0]
        .req_length             (req_length),           //input [2:0]
        .req_data               (req_data),             //input [31:0]
        .avalon_io_readdata     (avalon_io_readdata),   //input [31:0]
        .avalon_io_writedata    (avalon_io_writedata),  //output [31:0]
        .io_read_data           (io_read_data)          //output [31:0]
    );

endmodule

// File: hdl/io_bus_pkg.sv
/* I/O bus format */

package io_bus_pkg;

    // ----------------------------------------
    // widths of the x86 I/O space and bus
    // ----------------------------------------

    localparam int IO_ADDR_W = 16;   // port address
    localparam int IO_DATA_W = 32;   // one dword per transaction
    localparam int IO_BE_W   = 4;    // one enable per byte lane

    // ----------------------------------------
    // byte lanes of one bus word
    // ----------------------------------------

    // the same dword, seen whole or lane by lane
    typedef union packed {
        logic [IO_DATA_W-1:0]      dword;   // as driven on or taken from the bus
        logic [IO_BE_W-1:0][7:0]   bytes;   // lane 0 is the low byte
    } io_lane_u;

endpackage

// File: hdl/io_ctrl_pkg.sv
/* I/O request sequencing */

package io_ctrl_pkg;

    // ----------------------------------------
    // request length
    // ----------------------------------------

    // bytes per port access, 1 to 4
    typedef logic [2:0] io_len_t;

    localparam io_len_t IO_MAX_LEN = 3'd4;   // a full dword

    // ----------------------------------------
    // split access phase
    // ----------------------------------------

    // an access crossing a dword runs as two transactions
    typedef enum logic {
        phase_first  = 1'b0,   // dword of the port address
        phase_second = 1'b1    // next dword, remaining bytes
    } io_phase_e;

endpackage

// File: hdl/io_data_aligner.sv
/* I/O byte lane aligner */

`timescale 1ns/1ns

module io_data_aligner (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  io_ctrl_pkg::io_phase_e               phase,
    input  logic                                 rd_capture,
    input  logic                                 last_capture,
    input  logic [1:0]                           req_offset,
    input  io_ctrl_pkg::io_len_t                 req_length,
    input  logic [io_bus_pkg::IO_DATA_W-1:0]     req_data,
    input  logic [io_bus_pkg::IO_DATA_W-1:0]     avalon_io_readdata,
    output logic [io_bus_pkg::IO_DATA_W-1:0]     avalon_io_writedata,
    output logic [io_bus_pkg::IO_DATA_W-1:0]     io_read_data
);

    import io_bus_pkg::*;
    import io_ctrl_pkg::*;

    io_lane_u data_word;    // request bytes, low byte first
    io_lane_u wr_word;
    io_lane_u rd_word;
    io_lane_u merge_q;
    io_lane_u merge_next;

    // request byte carried on a lane in the given phase, may be out of range
    function automatic int byte_index(input int lane, input io_phase_e ph,
                                      input logic [1:0] off);
        byte_index = lane + ((ph == phase_second) ? IO_BE_W : 0) - int'(off);
    endfunction

    assign data_word = req_data;
    assign rd_word   = avalon_io_readdata;

    // ----------------------------------------
    // write lanes
    // ----------------------------------------

    always_comb begin
        int k;
        wr_word = '0;   // lanes outside the access stay zero
        for (int i = 0; i < IO_BE_W; i++) begin
            k = byte_index(i, phase, req_offset);
            if (k >= 0 && k < int'(req_length)) begin
                wr_word.bytes[i] = data_word.bytes[k[1:0]];
            end
        end
    end

    assign avalon_io_writedata = wr_word.dword;

    // ----------------------------------------
    // read merge
    // ----------------------------------------

    always_comb begin
        int k;
        merge_next = '0;   // bytes above the length read as zero
        for (int b = 0; b < IO_BE_W; b++) begin
            if (b < int'(req_length)) begin
                merge_next.bytes[b] = merge_q.bytes[b];   // first phase bytes
            end
        end
        for (int i = 0; i < IO_BE_W; i++) begin
            k = byte_index(i, phase, req_offset);
            if (k >= 0 && k < int'(req_length)) begin
                merge_next.bytes[k[1:0]] = rd_word.bytes[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_capture) begin
            merge_q <= merge_next;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            io_read_data <= '0;
        end else if (last_capture) begin
            io_read_data <= merge_next.dword;   // valid with io_read_done
        end
    end

endmodule

// File: sources.f
+incdir+tests
hdl/io_bus_pkg.sv
hdl/io_ctrl_pkg.sv
hdl/io_access_splitter.sv
hdl/io_avalon_master.sv
hdl/io_data_aligner.sv
hdl/io_bridge_top.sv
tests/io_checker.sv
tests/tb_top.sv

// File: tests/io_tb_defs.svh
/* Testbench constants and slave data */

localparam int TB_SEED        = 22947;
localparam int NUM_REQUESTS   = 400;
localparam int RESET_CYCLES   = 16;
localparam int CYCLES_PER_REQ = 24;   // generous budget per request
localparam int MAX_CYCLES     = NUM_REQUESTS * CYCLES_PER_REQ + RESET_CYCLES;

// every port reads back as a mix of its own address bytes
function automatic logic [7:0] port_byte(input logic [15:0] port);
    return port[7:0] ^ port[15:8] ^ 8'h5a;
endfunction

// File: tests/io_checker.sv
/* I/O bridge checker */

`timescale 1ns/1ns

module io_checker (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        io_read_do,
    input  logic        io_write_do,
    input  logic [15:0] io_address,
    input  logic [2:0]  io_length,
    input  logic [31:0] io_write_data,
    input  logic [31:0] io_read_data,
    input  logic        io_read_done,
    input  logic        io_write_done,
    input  logic [15:0] avalon_io_address,
    input  logic [3:0]  avalon_io_byteenable,
    input  logic        avalon_io_read,
    input  logic        avalon_io_write,
    input  logic [31:0] avalon_io_writedata,
    input  logic        avalon_io_waitrequest,
    output int          error_count,
    output int          check_count,
    output int          done_count
);

    `include "io_tb_defs.svh"

    logic        pending;        // request between strobe and done
    logic        seen_request;
    logic        exp_write;
    logic [15:0] exp_addr;
    logic [31:0] exp_data;
    int          exp_len;
    int          xfers;          // bus transfers accepted for this request

    // ----------------------------------------
    // reference model
    // ----------------------------------------

    function automatic logic split_access(input logic [1:0] off, input int len);
        return (int'(off) + len) > 4;
    endfunction

    function automatic logic [3:0] lane_enables(input logic [1:0] off, input int len,
                                                input logic second);
        int         o;
        logic [3:0] be;
        o = int'(off);
        for (int l = 0; l < 4; l++) begin
            if (second) begin
                be[l] = (l < o + len - 4);   // leftover bytes from lane 0
            end else begin
                be[l] = (l >= o) && (l <= o + len - 1);
            end
        end
        return be;
    endfunction

    function automatic logic [31:0] lane_mask(input logic [3:0] be);
        logic [31:0] m;
        for (int l = 0; l < 4; l++) begin
            m[8*l +: 8] = {8{be[l]}};
        end
        return m;
    endfunction

    function automatic logic [31:0] expected_lanes(input logic [31:0] data,
                                                   input logic [1:0] off,
                                                   input logic [3:0] be, input logic second);
        logic [31:0] w;
        int          idx;
        w = '0;
        for (int l = 0; l < 4; l++) begin
            idx = second ? l + 4 - int'(off) : l - int'(off);
            if (be[l]) begin
                w[8*l +: 8] = data[8*idx +: 8];
            end
        end
        return w;
    endfunction

    function automatic logic [31:0] expected_read(input logic [15:0] addr, input int len);
        logic [31:0] w;
        w = '0;   // bytes above the length stay zero
        for (int b = 0; b < len; b++) begin
            w[8*b +: 8] = port_byte(addr + 16'(b));
        end
        return w;
    endfunction

    // ----------------------------------------
    // comparison
    // ----------------------------------------

    task automatic compare_word(input logic [31:0] actual, input logic [31:0] expected,
                                input string what);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("[ERROR] %0t: %s is %h, expected %h", $time, what, actual, expected);
        end
    endtask

    task automatic report_protocol(input string what);
        error_count++;
        $display("protocol failure at %0t: %s", $time, what);
    endtask

    always @(posedge clk) begin
        logic        second;
        logic [3:0]  be;
        logic [15:0] dw;
        if (!rst_n) begin
            pending      = 1'b0;
            seen_request = 1'b0;
            xfers        = 0;
            error_count  = 0;
            check_count  = 0;
            done_count   = 0;
        end else begin
            if (!seen_request && (avalon_io_read || avalon_io_write
                                  || io_read_done || io_write_done)) begin
                report_protocol("bus or done strobe raised before any request");
            end
            if (io_read_done || io_write_done) begin
                done_count++;
                if (!pending) begin
                    report_protocol("done strobe with no request outstanding");
                end else begin
                    compare_word(32'({io_read_done, io_write_done}),
                                 exp_write ? 32'd1 : 32'd2, "done strobes {read, write}");
                    compare_word(32'(xfers), split_access(exp_addr[1:0], exp_len) ? 32'd2 : 32'd1,
                                 "bus transfers per request");
                    if (!exp_write) begin
                        compare_word(io_read_data, expected_read(exp_addr, exp_len), "read data");
                    end
                end
                pending = 1'b0;
            end
            if ((avalon_io_read || avalon_io_write) && !avalon_io_waitrequest) begin
                second = (xfers == 1);
                be     = lane_enables(exp_addr[1:0], exp_len, second);
                dw     = {exp_addr[15:2], 2'b00} + (second ? 16'd4 : 16'd0);   // wraps at 64k
                if (!pending) begin
                    report_protocol("bus transfer with no request outstanding");
                end else begin
                    compare_word(32'(avalon_io_write), 32'(exp_write), "bus write strobe");
                    compare_word(32'(avalon_io_address), 32'(dw), "bus address");
                    compare_word(32'(avalon_io_byteenable), 32'(be), "byte enables");
                    if (exp_write) begin
                        compare_word(avalon_io_writedata & lane_mask(be),
                                     expected_lanes(exp_data, exp_addr[1:0], be, second),
                                     "write lanes");
                    end
                end
                xfers++;
            end
            if (io_read_do || io_write_do) begin
                if (pending) begin
                    report_protocol("new request before the previous done strobe");
                end
                pending      = 1'b1;
                seen_request = 1'b1;
                exp_write    = io_write_do;
                exp_addr     = io_address;
                exp_len      = int'(io_length);
                exp_data     = io_write_data;
                xfers        = 0;
            end
        end
    end

endmodule

// File: tests/tb_top.sv
/* I/O bridge testbench */

`timescale 1ns/1ns

module tb_top;

    `include "io_tb_defs.svh"

    logic        clk = 1'b0;
    logic        rst_n;
    logic        io_read_do;
    logic        io_write_do;
    logic [15:0] io_address;
    logic [2:0]  io_length;
    logic [31:0] io_write_data;
    logic [31:0] io_read_data;
    logic        io_read_done;
    logic        io_write_done;
    logic [15:0] avalon_io_address;
    logic [3:0]  avalon_io_byteenable;
    logic        avalon_io_read;
    logic        avalon_io_write;
    logic [31:0] avalon_io_writedata;
    logic        avalon_io_waitrequest   = 1'b1;   // slave starts busy
    logic        avalon_io_readdatavalid = 1'b0;
    logic [31:0] avalon_io_readdata      = '0;

    logic [15:0] rd_addr     = '0;
    logic        rd_pending  = 1'b0;
    int          rd_delay    = 0;
    int          wait_left   = 0;
    int          bus_writes  = 0;
    int          exp_writes  = 0;   // write transfers the requests call for
    int          cycle_count = 0;
    int          req_count   = 0;
    int          error_count;
    int          check_count;
    int          done_count;

    always #50 clk = ~clk;   // 100 ns period

    io_bridge_top uut (.*);

    io_checker monitor (.*);

    // ----------------------------------------
    // Avalon slave model
    // ----------------------------------------

    function automatic logic [31:0] slave_word(input logic [15:0] dword);
        logic [31:0] w;
        for (int l = 0; l < 4; l++) begin
            w[8*l +: 8] = port_byte(dword + 16'(l));
        end
        return w;
    endfunction

    always @(posedge clk) begin
        int stall;
        avalon_io_readdatavalid <= 1'b0;
        if (rd_pending) begin
            if (rd_delay == 0) begin
                avalon_io_readdatavalid <= 1'b1;
                avalon_io_readdata      <= slave_word(rd_addr);
                rd_pending              <= 1'b0;
            end else begin
                rd_delay <= rd_delay - 1;
            end
        end
        if (avalon_io_read || avalon_io_write) begin
            if (!avalon_io_waitrequest) begin
                stall                 = int'($urandom % 4);
                avalon_io_waitrequest <= (stall != 0);   // no stall takes the next one at once
                wait_left             <= stall - 1;
                if (avalon_io_read) begin
                    rd_pending <= 1'b1;
                    rd_addr    <= avalon_io_address;
                    rd_delay   <= int'($urandom % 4);
                end else begin
                    bus_writes <= bus_writes + 1;
                end
            end else if (wait_left == 0) begin
                avalon_io_waitrequest <= 1'b0;
            end else begin
                wait_left <= wait_left - 1;
            end
        end
    end

    // ----------------------------------------
    // core side stimulus
    // ----------------------------------------

    task automatic issue_request(input logic wr, input logic [15:0] addr,
                                 input logic [2:0] len, input logic [31:0] data);
        io_address    <= addr;
        io_length     <= len;
        io_write_data <= data;
        io_read_do    <= ~wr;
        io_write_do   <= wr;
        @(posedge clk);
        io_read_do  <= 1'b0;
        io_write_do <= 1'b0;
        req_count++;
        do begin
            @(posedge clk);
        end while (!(io_read_done || io_write_done));
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("timeout: run still busy after %0d cycles, %0d requests issued",
                     cycle_count, req_count);
            $display("Some tests failed");
            $finish;
        end
    end

    initial begin
        logic        wr;
        logic [1:0]  off;
        logic [2:0]  len;
        logic [15:0] addr;
        void'($urandom(TB_SEED));
        rst_n         = 1'b0;
        io_read_do    = 1'b0;
        io_write_do   = 1'b0;
        io_address    = '0;
        io_length     = 3'd1;
        io_write_data = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        repeat (3) @(posedge clk);   // quiet bus expected here
        for (int n = 0; n < NUM_REQUESTS; n++) begin
            if (n < 32) begin
                wr  = n[0];   // every length at every offset, read and write
                off = n[2:1];
                len = {1'b0, n[4:3]} + 3'd1;
            end else begin
                wr  = 1'($urandom);
                off = 2'($urandom);
                len = 3'($urandom % 4) + 3'd1;
            end
            addr      = 16'($urandom);
            addr[1:0] = off;
            if (wr) begin
                exp_writes += ((int'(off) + int'(len)) > 4) ? 2 : 1;   // two when split
            end
            issue_request(wr, addr, len, $urandom);
        end
        @(posedge clk);
        if (done_count != req_count) begin
            $display("done strobes %0d do not match requests %0d", done_count, req_count);
        end
        if (bus_writes != exp_writes) begin
            $display("slave accepted %0d bus writes, %0d expected", bus_writes, exp_writes);
        end
        $display("requests %0d, done strobes %0d, bus writes %0d, checks %0d, errors %0d",
                 req_count, done_count, bus_writes, check_count, error_count);
        if (error_count == 0 && done_count == req_count && bus_writes == exp_writes) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule
